// ==== design/exec_consts.svh ====
// Widths and link steps of the execute stage; RV32 only, shifts limited to 5-bit amounts
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Register and address width
`define EXEC_XLEN       32

// Flow tag width, wraps after 8 redirects
`define EXEC_TAG_W      3

// Low bits of the second operand used by shifts
`define EXEC_SHAMT_W    5

// One write enable per byte of a word
`define EXEC_BE_W       4

// Link offsets for normal and compressed instructions
`define EXEC_PC_STEP    4
`define EXEC_PC_STEP_C  2

`endif

// ==== design/exec_pkg.sv ====
// Types shared by the execute stage; ops arrive already decoded, no CSR or M extension ops
`include "exec_consts.svh"

package exec_pkg;

    typedef enum logic [5:0] {
        NOP, ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU, LUI,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // Standard mcause encodings
    typedef enum logic [3:0] {
        INSTR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR    = 4'd2,
        BREAKPOINT       = 4'd3,
        ECALL_U          = 4'd8,
        ECALL_M          = 4'd11,
        NO_EXC           = 4'd15
    } exc_code_e;

    ////////////////////////////////////////
    // Records between stages and units
    ////////////////////////////////////////

    typedef struct packed {
        op_e                      op;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [`EXEC_XLEN-1:0]    first_op;
        logic [`EXEC_XLEN-1:0]    second_op;
        logic [`EXEC_XLEN-1:0]    third_op;
        logic                     compressed;
        logic [`EXEC_TAG_W-1:0]   tag;
        logic                     illegal;
        logic                     misaligned_fetch;
    } issue_t;

    typedef struct packed {
        logic                     eq;
        logic                     lt;
        logic                     ltu;
        logic [`EXEC_XLEN-1:0]    sum;
    } cmp_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]    addr;
        logic                     read_en;
        logic [`EXEC_BE_W-1:0]    write_be;
        logic [`EXEC_XLEN-1:0]    write_data;
    } mem_req_t;

    typedef struct packed {
        logic                     taken;
        logic [`EXEC_XLEN-1:0]    target;
    } redirect_t;

    typedef struct packed {
        logic                     raise;
        logic                     mret;
        exc_code_e                code;
    } trap_t;

    typedef struct packed {
        logic                     write_en;
        op_e                      op;
        logic [`EXEC_XLEN-1:0]    result;
    } wb_t;

endpackage

// ==== design/alu_core.sv ====
// Combinational ALU; LUI expects the shifted immediate on the second operand
`timescale 1ns/100ps
`include "exec_consts.svh"

module alu_core (
    input   exec_pkg::issue_t           issue_i,
    output  logic [`EXEC_XLEN-1:0]      result_o,
    output  exec_pkg::cmp_t             cmp_o
);

    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0]      op_a;
    logic [`EXEC_XLEN-1:0]      op_b;
    logic [`EXEC_SHAMT_W-1:0]   shamt;

    logic [`EXEC_XLEN-1:0]      sum2_a;
    logic [`EXEC_XLEN-1:0]      sum2_b;
    logic [`EXEC_XLEN-1:0]      sum;
    logic [`EXEC_XLEN-1:0]      sum2;
    logic [`EXEC_XLEN-1:0]      sll_res;
    logic [`EXEC_XLEN-1:0]      srl_res;
    logic [`EXEC_XLEN-1:0]      sra_res;
    logic                       lt;
    logic                       ltu;

    assign op_a  = issue_i.first_op;
    assign op_b  = issue_i.second_op;
    assign shamt = op_b[`EXEC_SHAMT_W-1:0];

    ////////////////////////////////////////
    // Adders
    ////////////////////////////////////////

    // Second adder forms sub, the link value or pc plus the offset
    always_comb begin
        case (issue_i.op)
            SUB:     sum2_a = op_a;
            default: sum2_a = issue_i.pc;
        endcase
    end

    always_comb begin
        case (issue_i.op)
            JAL, JALR: begin
                sum2_b = issue_i.compressed ? `EXEC_XLEN'(`EXEC_PC_STEP_C)
                                            : `EXEC_XLEN'(`EXEC_PC_STEP);
            end
            SUB:       sum2_b = -op_b;
            default:   sum2_b = issue_i.third_op;
        endcase
    end

    assign sum  = op_a + op_b;
    assign sum2 = sum2_a + sum2_b;

    ////////////////////////////////////////
    // Shifts and compares
    ////////////////////////////////////////

    assign sll_res = op_a << shamt;
    assign srl_res = op_a >> shamt;
    assign sra_res = $signed(op_a) >>> shamt;

    assign lt  = $signed(op_a) < $signed(op_b);
    assign ltu = op_a < op_b;

    // Loads and stores take the address sum from the default arm
    always_comb begin
        case (issue_i.op)
            SUB, JAL, JALR: result_o = sum2;
            AND:            result_o = op_a & op_b;
            OR:             result_o = op_a | op_b;
            XOR:            result_o = op_a ^ op_b;
            SLL:            result_o = sll_res;
            SRL:            result_o = srl_res;
            SRA:            result_o = sra_res;
            SLT:            result_o = {{(`EXEC_XLEN-1){1'b0}}, lt};
            SLTU:           result_o = {{(`EXEC_XLEN-1){1'b0}}, ltu};
            LUI:            result_o = op_b;
            default:        result_o = sum;
        endcase
    end

    // Flags and sum for the branch and memory units
    assign cmp_o.eq  = (op_a == op_b);
    assign cmp_o.lt  = lt;
    assign cmp_o.ltu = ltu;
    assign cmp_o.sum = sum;

endmodule

// ==== design/branch_unit.sv ====
// Raw branch decision; killing and trap gating are applied later in flow control
`timescale 1ns/100ps
`include "exec_consts.svh"

module branch_unit (
    input   exec_pkg::issue_t           issue_i,
    input   exec_pkg::cmp_t             cmp_i,
    output  logic                       taken_o,
    output  logic [`EXEC_XLEN-1:0]      target_o
);

    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0]  branch_target;

    // Conditional branches use pc plus the offset on the third operand
    assign branch_target = issue_i.pc + issue_i.third_op;

    ////////////////////////////////////////
    // Condition
    ////////////////////////////////////////

    always_comb begin
        case (issue_i.op)
            BEQ:       taken_o = cmp_i.eq;
            BNE:       taken_o = ~cmp_i.eq;
            BLT:       taken_o = cmp_i.lt;
            BLTU:      taken_o = cmp_i.ltu;
            BGE:       taken_o = ~cmp_i.lt;
            BGEU:      taken_o = ~cmp_i.ltu;
            JAL, JALR: taken_o = 1'b1;
            default:   taken_o = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Target
    ////////////////////////////////////////

    // Jumps take the operand sum, jalr clears bit 0
    always_comb begin
        case (issue_i.op)
            JALR:    target_o = {cmp_i.sum[`EXEC_XLEN-1:1], 1'b0};
            JAL:     target_o = cmp_i.sum;
            default: target_o = branch_target;
        endcase
    end

endmodule

// ==== design/lsu_request.sv ====
// Word-aligned data memory request; misaligned halfword and word accesses are not trapped
`timescale 1ns/100ps
`include "exec_consts.svh"

module lsu_request (
    input   exec_pkg::issue_t           issue_i,
    input   logic [`EXEC_XLEN-1:0]      sum_i,
    output  exec_pkg::mem_req_t         mem_o
);

    import exec_pkg::*;

    logic [1:0]     byte_sel;

    assign byte_sel = sum_i[1:0];

    // Address always points at the containing word
    assign mem_o.addr    = {sum_i[`EXEC_XLEN-1:2], 2'b00};
    assign mem_o.read_en = issue_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // Store data and byte lanes
    ////////////////////////////////////////

    // Replicate so the selected lanes carry the value
    always_comb begin
        case (issue_i.op)
            SB:      mem_o.write_data = {4{issue_i.third_op[7:0]}};
            SH:      mem_o.write_data = {2{issue_i.third_op[15:0]}};
            default: mem_o.write_data = issue_i.third_op;
        endcase
    end

    always_comb begin
        case (issue_i.op)
            SB: begin
                case (byte_sel)
                    2'b11:   mem_o.write_be = 4'b1000;
                    2'b10:   mem_o.write_be = 4'b0100;
                    2'b01:   mem_o.write_be = 4'b0010;
                    default: mem_o.write_be = 4'b0001;
                endcase
            end
            SH: begin
                // Upper or lower halfword by address bit 1
                mem_o.write_be = byte_sel[1] ? 4'b1100 : 4'b0011;
            end
            SW:      mem_o.write_be = 4'b1111;
            default: mem_o.write_be = '0;
        endcase
    end

endmodule

// ==== design/flow_control.sv ====
// Tag based kill and trap priority; flow tag advances on redirect, trap or mret, ignoring stall
`timescale 1ns/100ps
`include "exec_consts.svh"

module flow_control (
    input   logic                       clk,
    input   logic                       reset_n,
    input   exec_pkg::issue_t           issue_i,
    input   logic                       flush_i,
    input   exec_pkg::priv_e            priv_i,
    input   logic                       taken_i,
    input   logic [`EXEC_XLEN-1:0]      target_i,
    output  logic                       killed_o,
    output  exec_pkg::redirect_t        redirect_o,
    output  exec_pkg::trap_t            trap_o,
    output  logic                       commit_o
);

    import exec_pkg::*;

    logic [`EXEC_TAG_W-1:0]     flow_tag;
    logic                       killed;
    logic                       writes_reg;

    ////////////////////////////////////////
    // Kill detection
    ////////////////////////////////////////

    // Stale tag means the instruction came from an abandoned path
    assign killed   = (issue_i.tag != flow_tag) | flush_i;
    assign killed_o = killed;

    assign redirect_o.taken  = taken_i & ~killed;
    assign redirect_o.target = target_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            flow_tag <= '0;
        end
        else if (redirect_o.taken | trap_o.raise | trap_o.mret) begin
            flow_tag <= flow_tag + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Trap priority
    ////////////////////////////////////////

    always_comb begin
        trap_o.raise = 1'b0;
        trap_o.mret  = 1'b0;
        trap_o.code  = NO_EXC;
        if (!killed) begin
            if (issue_i.misaligned_fetch) begin
                trap_o.raise = 1'b1;
                trap_o.code  = INSTR_MISALIGNED;
            end
            else if (issue_i.illegal) begin
                trap_o.raise = 1'b1;
                trap_o.code  = ILLEGAL_INSTR;
            end
            else if (issue_i.op == ECALL) begin
                trap_o.raise = 1'b1;
                trap_o.code  = (priv_i == USER) ? ECALL_U : ECALL_M;
            end
            else if (issue_i.op == EBREAK) begin
                trap_o.raise = 1'b1;
                trap_o.code  = BREAKPOINT;
            end
            else if (issue_i.op == MRET) begin
                // Return only, no cause
                trap_o.mret = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Commit
    ////////////////////////////////////////

    assign writes_reg = !(issue_i.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU,
                                             ECALL, EBREAK, MRET});

    assign commit_o = writes_reg & ~killed & ~trap_o.raise;

endmodule

// ==== design/execute_stage.sv ====
// Execute stage top; single-cycle ops only, stall_i is the sole back-pressure
`timescale 1ns/100ps
`include "exec_consts.svh"

module execute_stage (
    input   logic                       clk,
    input   logic                       reset_n,
    input   exec_pkg::issue_t           issue_i,
    input   logic                       stall_i,
    input   logic                       flush_i,
    input   exec_pkg::priv_e            priv_i,
    output  exec_pkg::wb_t              wb_o,
    output  exec_pkg::mem_req_t         mem_o,
    output  exec_pkg::redirect_t        redirect_o,
    output  exec_pkg::trap_t            trap_o,
    output  logic                       killed_o
);

    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0]  alu_result;
    cmp_t                   cmp;
    logic                   br_taken;
    logic [`EXEC_XLEN-1:0]  br_target;
    logic                   commit;

    ////////////////////////////////////////
    // Units
    ////////////////////////////////////////

    alu_core u_alu (
        .issue_i    (issue_i),
        .result_o   (alu_result),
        .cmp_o      (cmp)
    );

    branch_unit u_branch (
        .issue_i    (issue_i),
        .cmp_i      (cmp),
        .taken_o    (br_taken),
        .target_o   (br_target)
    );

    // Killed requests still go out, memory squashes them downstream
    lsu_request u_lsu (
        .issue_i    (issue_i),
        .sum_i      (cmp.sum),
        .mem_o      (mem_o)
    );

    flow_control u_flow (
        .clk        (clk),
        .reset_n    (reset_n),
        .issue_i    (issue_i),
        .flush_i    (flush_i),
        .priv_i     (priv_i),
        .taken_i    (br_taken),
        .target_i   (br_target),
        .killed_o   (killed_o),
        .redirect_o (redirect_o),
        .trap_o     (trap_o),
        .commit_o   (commit)
    );

    ////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////

    // Holds its contents while stalled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o.write_en <= 1'b0;
            wb_o.op       <= NOP;
            wb_o.result   <= '0;
        end
        else if (!stall_i) begin
            wb_o.write_en <= commit;
            wb_o.op       <= issue_i.op;
            wb_o.result   <= alu_result;
        end
    end

endmodule

// ==== verification/execute_assert.sv ====
// Port checker bound into execute_stage; keeps its own flow tag model, counts failures in errors
`timescale 1ns/100ps
`include "exec_consts.svh"

module execute_assert (
    input   logic                       clk,
    input   logic                       reset_n,
    input   exec_pkg::issue_t           issue_i,
    input   logic                       stall_i,
    input   logic                       flush_i,
    input   exec_pkg::priv_e            priv_i,
    input   exec_pkg::wb_t              wb_o,
    input   exec_pkg::mem_req_t         mem_o,
    input   exec_pkg::redirect_t        redirect_o,
    input   exec_pkg::trap_t            trap_o,
    input   logic                       killed_o
);

    import exec_pkg::*;

    int                         errors = 0;
    logic [`EXEC_TAG_W-1:0]     model_tag;
    logic                       exp_killed;
    logic                       exp_taken;
    logic                       exp_writes;
    logic [`EXEC_XLEN-1:0]      a;
    logic [`EXEC_XLEN-1:0]      b;
    logic [`EXEC_XLEN-1:0]      sum;
    logic [`EXEC_XLEN-1:0]      exp_result;
    redirect_t                  exp_redirect;
    trap_t                      exp_trap;
    mem_req_t                   exp_mem;
    wb_t                        exp_wb;

    assign a   = issue_i.first_op;
    assign b   = issue_i.second_op;
    assign sum = a + b;

    assign exp_killed = (issue_i.tag != model_tag) || flush_i;
    assign exp_writes = !(issue_i.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU,
                                             ECALL, EBREAK, MRET});

    ////////////////////////////////////////
    // Expected values
    ////////////////////////////////////////

    always_comb begin
        exp_taken           = 1'b0;
        exp_result          = sum;
        exp_redirect.target = issue_i.pc + issue_i.third_op;
        case (issue_i.op)
            SUB:  exp_result = a - b;
            AND:  exp_result = a & b;
            OR:   exp_result = a | b;
            XOR:  exp_result = a ^ b;
            SLL:  exp_result = a << b[4:0];
            SRL:  exp_result = a >> b[4:0];
            SRA:  exp_result = 32'($signed(a) >>> b[4:0]);
            SLT:  exp_result = {31'b0, $signed(a) < $signed(b)};
            SLTU: exp_result = {31'b0, a < b};
            LUI:  exp_result = b;
            JAL, JALR: begin
                exp_taken           = 1'b1;
                exp_result          = issue_i.pc + (issue_i.compressed ? 32'd2 : 32'd4);
                exp_redirect.target = (issue_i.op == JALR) ? {sum[31:1], 1'b0} : sum;
            end
            BEQ:  exp_taken = (a == b);
            BNE:  exp_taken = (a != b);
            BLT:  exp_taken = $signed(a) < $signed(b);
            BLTU: exp_taken = a < b;
            BGE:  exp_taken = $signed(a) >= $signed(b);
            BGEU: exp_taken = a >= b;
            default: ;
        endcase
        exp_redirect.taken = exp_taken & ~exp_killed;
    end

    // Priority order fetch misalign, illegal, ecall, ebreak, mret
    always_comb begin
        exp_trap = '{1'b0, 1'b0, NO_EXC};
        if (!exp_killed) begin
            if (issue_i.misaligned_fetch)
                exp_trap = '{1'b1, 1'b0, INSTR_MISALIGNED};
            else if (issue_i.illegal)
                exp_trap = '{1'b1, 1'b0, ILLEGAL_INSTR};
            else if (issue_i.op == ECALL)
                exp_trap = '{1'b1, 1'b0, (priv_i == MACHINE) ? ECALL_M : ECALL_U};
            else if (issue_i.op == EBREAK)
                exp_trap = '{1'b1, 1'b0, BREAKPOINT};
            else if (issue_i.op == MRET)
                exp_trap = '{1'b0, 1'b1, NO_EXC};
        end
    end

    always_comb begin
        exp_mem.addr       = sum & ~32'd3;
        exp_mem.read_en    = issue_i.op inside {LB, LBU, LH, LHU, LW};
        exp_mem.write_be   = 4'b0000;
        exp_mem.write_data = issue_i.third_op;
        case (issue_i.op)
            SB: begin
                exp_mem.write_be   = 4'b0001 << sum[1:0];
                exp_mem.write_data = {4{issue_i.third_op[7:0]}};
            end
            SH: begin
                exp_mem.write_be   = sum[1] ? 4'b1100 : 4'b0011;
                exp_mem.write_data = {2{issue_i.third_op[15:0]}};
            end
            SW:      exp_mem.write_be = 4'b1111;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            model_tag <= '0;
            exp_wb    <= '{1'b0, NOP, 32'd0};
        end
        else begin
            if (exp_redirect.taken | exp_trap.raise | exp_trap.mret) begin
                model_tag <= model_tag + 1'b1;
            end
            if (!stall_i) begin
                exp_wb <= '{exp_writes & ~exp_killed & ~exp_trap.raise, issue_i.op, exp_result};
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_wb: assert property (@(posedge clk) disable iff (!reset_n) wb_o == exp_wb)
        else begin
            $error("Mismatch wb: expected %h actual %h", $sampled(exp_wb), $sampled(wb_o));
            errors++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!reset_n) stall_i |=> $stable(wb_o))
        else begin
            $error("Writeback register changed on an edge where stall was high");
            errors++;
        end

    a_redirect: assert property (@(posedge clk) disable iff (!reset_n) redirect_o == exp_redirect)
        else begin
            $error("Mismatch redirect: expected %h actual %h",
                   $sampled(exp_redirect), $sampled(redirect_o));
            errors++;
        end

    a_mem: assert property (@(posedge clk) disable iff (!reset_n) mem_o == exp_mem)
        else begin
            $error("Mismatch mem: expected %h actual %h", $sampled(exp_mem), $sampled(mem_o));
            errors++;
        end

    a_trap: assert property (@(posedge clk) disable iff (!reset_n) trap_o == exp_trap)
        else begin
            $error("Mismatch trap: expected %h actual %h", $sampled(exp_trap), $sampled(trap_o));
            errors++;
        end

    a_killed: assert property (@(posedge clk) disable iff (!reset_n) killed_o == exp_killed)
        else begin
            $error("Mismatch killed: expected %b actual %b",
                   $sampled(exp_killed), $sampled(killed_o));
            errors++;
        end

endmodule

// ==== verification/execute_tb.sv ====
// Stimulus only; all checking sits in the bound execute_assert instance chk
`timescale 1ns/100ps
`include "exec_consts.svh"

module execute_tb;

    import exec_pkg::*;

    localparam int RAND_COUNT  = 400;
    localparam int CYCLE_LIMIT = 10 + RAND_COUNT + 40 + 100;

    logic                       clk;
    logic                       reset_n;
    logic                       stall_i;
    logic                       flush_i;
    issue_t                     issue_i;
    priv_e                      priv_i;
    wb_t                        wb_o;
    mem_req_t                   mem_o;
    redirect_t                  redirect_o;
    trap_t                      trap_o;
    logic                       killed_o;
    logic [31:0]                rng = 32'h0fca61fc;
    logic [`EXEC_TAG_W-1:0]     tag_copy;
    int                         cycles = 0;

    execute_stage dut0 (.*);

    bind execute_stage execute_assert chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // True when an unkilled instruction moves fetch elsewhere
    function automatic logic redirects(input op_e op, input logic [31:0] a, input logic [31:0] b,
                                       input logic ill, input logic mis);
        if (ill || mis)
            return 1'b1;
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BLTU:    return a < b;
            BGE:     return $signed(a) >= $signed(b);
            BGEU:    return a >= b;
            JAL, JALR, ECALL, EBREAK, MRET: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic drive(input op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c, input logic ill, input logic mis,
                         input logic stale);
        rng = xorshift(rng);
        issue_i.op               = op;
        issue_i.pc               = {rng[31:1], 1'b0};
        issue_i.first_op         = a;
        issue_i.second_op        = b;
        issue_i.third_op         = c;
        issue_i.compressed       = rng[0];
        issue_i.tag              = stale ? tag_copy - 3'd1 : tag_copy;
        issue_i.illegal          = ill;
        issue_i.misaligned_fetch = mis;
        if (!stale && !flush_i && redirects(op, a, b, ill, mis)) begin
            tag_copy = tag_copy + 3'd1;
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run passed the limit of %0d cycles before the tests ended", CYCLE_LIMIT);
            $display("Assertion failures: %0d, timeouts: 1", dut0.chk.errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r_op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        issue_i  = '0;
        stall_i  = 1'b0;
        flush_i  = 1'b0;
        priv_i   = USER;
        reset_n  = 1'b0;
        tag_copy = '0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        ////////////////////////////////////////
        // Directed
        ////////////////////////////////////////
        drive(ADD, 32'd5, 32'd7, 32'd0, 1'b0, 1'b0, 1'b0);
        // Hold an instruction under stall for three edges
        stall_i = 1'b1;
        drive(XOR, 32'h1234, 32'hff00, 32'd0, 1'b0, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        #1;
        stall_i = 1'b0;
        @(posedge clk);
        #1;
        drive(BEQ, 32'd4, 32'd4, 32'h40, 1'b0, 1'b0, 1'b0);
        drive(BNE, 32'd4, 32'd4, 32'h40, 1'b0, 1'b0, 1'b0);
        drive(JALR, 32'h101, 32'h10, 32'd0, 1'b0, 1'b0, 1'b0);
        drive(JAL, 32'h200, 32'h8, 32'd0, 1'b0, 1'b0, 1'b0);
        drive(ADD, 32'd1, 32'd2, 32'd0, 1'b0, 1'b0, 1'b1);
        flush_i = 1'b1;
        drive(JAL, 32'h300, 32'h4, 32'd0, 1'b0, 1'b0, 1'b0);
        flush_i = 1'b0;
        drive(ECALL, 32'd0, 32'd0, 32'd0, 1'b1, 1'b1, 1'b0);
        drive(ECALL, 32'd0, 32'd0, 32'd0, 1'b1, 1'b0, 1'b0);
        drive(ECALL, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
        priv_i = MACHINE;
        drive(ECALL, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
        drive(EBREAK, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
        drive(MRET, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
        drive(SLL, 32'd3, 32'd4, 32'd0, 1'b0, 1'b0, 1'b1);

        ////////////////////////////////////////
        // Random
        ////////////////////////////////////////
        for (int i = 0; i < RAND_COUNT; i++) begin
            rng = xorshift(rng);
            r_op = rng;
            rng = xorshift(rng);
            a = rng;
            rng = xorshift(rng);
            b = rng[3] ? rng : a;
            rng = xorshift(rng);
            c = rng;
            priv_i  = r_op[8] ? MACHINE : USER;
            stall_i = (r_op[15:12] == 4'd0);
            drive(op_e'(6'(1 + r_op[7:0] % 8'd30)), a, b, c, r_op[23:16] == 8'd0,
                  r_op[31:24] == 8'd0, r_op[11:9] == 3'd0);
        end
        stall_i = 1'b0;
        drive(NOP, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);

        $display("Assertion failures: %0d, timeouts: 0", dut0.chk.errors);
        if (dut0.chk.errors == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/exec_pkg.sv
design/alu_core.sv
design/branch_unit.sv
design/lsu_request.sv
design/flow_control.sv
design/execute_stage.sv
verification/execute_assert.sv
verification/execute_tb.sv

// ==== Makefile ====
SOURCES := sim.f design/exec_consts.svh $(wildcard design/*.sv) $(wildcard verification/*.sv)

.PHONY: run clean

run: obj_dir/Vexecute_tb
	@out="$$(./obj_dir/Vexecute_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Simulation passed'

obj_dir/Vexecute_tb: $(SOURCES)
	verilator --binary --assert --top-module execute_tb -f sim.f

clean:
	rm -rf obj_dir
